/* src/bgm_pkg.sv */
package bgm_pkg;

  // song pitches with p_rest as silence
  typedef enum logic [4:0] {
    p_rest,
    p_e4,
    p_g4,
    p_g4s,
    p_a4,
    p_a4s,
    p_b4,
    p_c5,
    p_d5,
    p_d5s,
    p_e5,
    p_f5,
    p_f5s,
    p_g5,
    p_a5,
    p_c6
  } pitch_e;

  typedef enum logic [0:0] {
    dur_eighth,
    dur_quarter
  } dur_e;

  typedef struct packed {
    pitch_e pitch;
    dur_e   dur;
  } note_t;

  typedef logic [17:0] half_period_t; // clock cycles per tone half-period
  typedef logic [7:0]  song_pos_t;
  typedef logic [8:0]  beat_cnt_t;

  localparam song_pos_t SONG_LAST = 8'd188; // wraps to 0 after this note

  localparam int TICK_DIV_DEFAULT    = 100000; // 1 ms tick at 100 MHz
  localparam int PITCH_SHIFT_DEFAULT = 0;

  // last audible tick and last tick of each note length
  localparam beat_cnt_t EIGHTH_SOUND_TICKS  = 9'd150;
  localparam beat_cnt_t EIGHTH_LAST_TICK    = 9'd200;
  localparam beat_cnt_t QUARTER_SOUND_TICKS = 9'd300;
  localparam beat_cnt_t QUARTER_LAST_TICK   = 9'd350;

  // divider constants for a 100 MHz clock
  function automatic half_period_t half_period_of(pitch_e pitch);
    half_period_t hp;
    case (pitch)
      p_e4:    hp = 18'd151515;
      p_g4:    hp = 18'd127551;
      p_g4s:   hp = 18'd120481;
      p_a4:    hp = 18'd113636;
      p_a4s:   hp = 18'd107296;
      p_b4:    hp = 18'd101215;
      p_c5:    hp = 18'd95602;
      p_d5:    hp = 18'd85178;
      p_d5s:   hp = 18'd80385;
      p_e5:    hp = 18'd75873;
      p_f5:    hp = 18'd71633;
      p_f5s:   hp = 18'd67658;
      p_g5:    hp = 18'd63776;
      p_a5:    hp = 18'd56818;
      p_c6:    hp = 18'd47801;
      default: hp = 18'd0; // rest
    endcase
    return hp;
  endfunction

endpackage

/* src/song_sequencer.sv */
`timescale 1ns/1ps

module song_sequencer import bgm_pkg::*; (
  input  logic      clk_100MHz,
  input  logic      reset,
  input  logic      next_note,
  output song_pos_t song_pos,
  output note_t     cur_note
);

  always_ff @(posedge clk_100MHz) begin
    if (reset) begin
      song_pos <= '0;
    end else if (next_note) begin
      if (song_pos == SONG_LAST) begin
        song_pos <= '0; // loop the song
      end else begin
        song_pos <= song_pos + 1'b1;
      end
    end
  end

  always_comb begin
    case (song_pos)
      8'd0:    cur_note = '{p_e5, dur_eighth};   // E5
      8'd1:    cur_note = '{p_e5, dur_eighth};   // E5
      8'd2:    cur_note = '{p_rest, dur_eighth}; // rest
      8'd3:    cur_note = '{p_e5, dur_eighth};   // E5
      8'd4:    cur_note = '{p_rest, dur_eighth}; // rest
      8'd5:    cur_note = '{p_c5, dur_eighth};   // C5
      8'd6:    cur_note = '{p_e5, dur_quarter};  // E5
      8'd7:    cur_note = '{p_g5, dur_quarter};  // G5
      8'd8:    cur_note = '{p_rest, dur_quarter}; // rest
      8'd9:    cur_note = '{p_g4, dur_quarter};  // G4
      8'd10:   cur_note = '{p_rest, dur_quarter}; // rest
      8'd11:   cur_note = '{p_c5, dur_quarter};  // C5
      8'd12:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd13:   cur_note = '{p_g4, dur_quarter};  // G4
      8'd14:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd15:   cur_note = '{p_e4, dur_quarter};  // E4
      8'd16:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd17:   cur_note = '{p_a4, dur_quarter};  // A4
      8'd18:   cur_note = '{p_b4, dur_quarter};  // B4
      8'd19:   cur_note = '{p_a4s, dur_eighth};  // A4#
      8'd20:   cur_note = '{p_a4, dur_quarter};  // A4
      8'd21:   cur_note = '{p_g4, dur_eighth};   // G4
      8'd22:   cur_note = '{p_e5, dur_eighth};   // E5
      8'd23:   cur_note = '{p_g5, dur_eighth};   // G5
      8'd24:   cur_note = '{p_a5, dur_quarter};  // A5
      8'd25:   cur_note = '{p_f5, dur_eighth};   // F5
      8'd26:   cur_note = '{p_g5, dur_eighth};   // G5
      8'd27:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd28:   cur_note = '{p_e5, dur_quarter};  // E5
      8'd29:   cur_note = '{p_c5, dur_eighth};   // C5
      8'd30:   cur_note = '{p_d5, dur_eighth};   // D5
      8'd31:   cur_note = '{p_b4, dur_quarter};  // B4
      8'd32:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd33:   cur_note = '{p_c5, dur_quarter};  // C5
      8'd34:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd35:   cur_note = '{p_g4, dur_quarter};  // G4
      8'd36:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd37:   cur_note = '{p_e4, dur_quarter};  // E4
      8'd38:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd39:   cur_note = '{p_a4, dur_quarter};  // A4
      8'd40:   cur_note = '{p_b4, dur_quarter};  // B4
      8'd41:   cur_note = '{p_a4s, dur_eighth};  // A4#
      8'd42:   cur_note = '{p_a4, dur_quarter};  // A4
      8'd43:   cur_note = '{p_g4, dur_eighth};   // G4
      8'd44:   cur_note = '{p_e5, dur_eighth};   // E5
      8'd45:   cur_note = '{p_g5, dur_eighth};   // G5
      8'd46:   cur_note = '{p_a5, dur_quarter};  // A5
      8'd47:   cur_note = '{p_f5, dur_eighth};   // F5
      8'd48:   cur_note = '{p_g5, dur_eighth};   // G5
      8'd49:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd50:   cur_note = '{p_e5, dur_quarter};  // E5
      8'd51:   cur_note = '{p_c5, dur_eighth};   // C5
      8'd52:   cur_note = '{p_d5, dur_eighth};   // D5
      8'd53:   cur_note = '{p_b4, dur_quarter};  // B4
      8'd54:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd55:   cur_note = '{p_rest, dur_quarter}; // rest
      8'd56:   cur_note = '{p_g5, dur_eighth};   // G5
      8'd57:   cur_note = '{p_f5s, dur_eighth};  // F5#
      8'd58:   cur_note = '{p_f5, dur_eighth};   // F5
      8'd59:   cur_note = '{p_d5s, dur_quarter}; // D5#
      8'd60:   cur_note = '{p_e5, dur_quarter};  // E5
      8'd61:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd62:   cur_note = '{p_g4s, dur_eighth};  // G4#
      8'd63:   cur_note = '{p_a4, dur_eighth};   // A4
      8'd64:   cur_note = '{p_c5, dur_eighth};   // C5
      8'd65:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd66:   cur_note = '{p_a4, dur_eighth};   // A4
      8'd67:   cur_note = '{p_c5, dur_eighth};   // C5
      8'd68:   cur_note = '{p_d5, dur_eighth};   // D5
      8'd69:   cur_note = '{p_rest, dur_quarter}; // rest
      8'd70:   cur_note = '{p_g5, dur_eighth};   // G5
      8'd71:   cur_note = '{p_f5s, dur_eighth};  // F5#
      8'd72:   cur_note = '{p_f5, dur_eighth};   // F5
      8'd73:   cur_note = '{p_d5s, dur_quarter}; // D5#
      8'd74:   cur_note = '{p_e5, dur_quarter};  // E5
      8'd75:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd76:   cur_note = '{p_c6, dur_quarter};  // C6
      8'd77:   cur_note = '{p_c6, dur_eighth};   // C6
      8'd78:   cur_note = '{p_c6, dur_quarter};  // C6
      8'd79:   cur_note = '{p_rest, dur_quarter}; // rest
      8'd80:   cur_note = '{p_rest, dur_quarter}; // rest
      8'd81:   cur_note = '{p_g5, dur_eighth};   // G5
      8'd82:   cur_note = '{p_f5s, dur_eighth};  // F5#
      8'd83:   cur_note = '{p_f5, dur_eighth};   // F5
      8'd84:   cur_note = '{p_d5s, dur_quarter}; // D5#
      8'd85:   cur_note = '{p_e5, dur_quarter};  // E5
      8'd86:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd87:   cur_note = '{p_g4s, dur_eighth};  // G4#
      8'd88:   cur_note = '{p_a4, dur_eighth};   // A4
      8'd89:   cur_note = '{p_c5, dur_eighth};   // C5
      8'd90:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd91:   cur_note = '{p_a4, dur_eighth};   // A4
      8'd92:   cur_note = '{p_c5, dur_eighth};   // C5
      8'd93:   cur_note = '{p_d5, dur_eighth};   // D5
      8'd94:   cur_note = '{p_rest, dur_quarter}; // rest
      8'd95:   cur_note = '{p_d5s, dur_quarter}; // D5#
      8'd96:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd97:   cur_note = '{p_d5, dur_quarter};  // D5
      8'd98:   cur_note = '{p_rest, dur_eighth}; // rest
      8'd99:   cur_note = '{p_c5, dur_quarter};  // C5
      8'd100:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd101:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd102:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd103:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd104:  cur_note = '{p_g5, dur_eighth};   // G5
      8'd105:  cur_note = '{p_f5s, dur_eighth};  // F5#
      8'd106:  cur_note = '{p_f5, dur_eighth};   // F5
      8'd107:  cur_note = '{p_d5s, dur_quarter}; // D5#
      8'd108:  cur_note = '{p_e5, dur_quarter};  // E5
      8'd109:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd110:  cur_note = '{p_g4s, dur_eighth};  // G4#
      8'd111:  cur_note = '{p_a4, dur_eighth};   // A4
      8'd112:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd113:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd114:  cur_note = '{p_a4, dur_eighth};   // A4
      8'd115:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd116:  cur_note = '{p_d5, dur_eighth};   // D5
      8'd117:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd118:  cur_note = '{p_g5, dur_eighth};   // G5
      8'd119:  cur_note = '{p_f5s, dur_eighth};  // F5#
      8'd120:  cur_note = '{p_f5, dur_eighth};   // F5
      8'd121:  cur_note = '{p_d5s, dur_quarter}; // D5#
      8'd122:  cur_note = '{p_e5, dur_quarter};  // E5
      8'd123:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd124:  cur_note = '{p_c6, dur_quarter};  // C6
      8'd125:  cur_note = '{p_c6, dur_eighth};   // C6
      8'd126:  cur_note = '{p_c6, dur_quarter};  // C6
      8'd127:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd128:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd129:  cur_note = '{p_g5, dur_eighth};   // G5
      8'd130:  cur_note = '{p_f5s, dur_eighth};  // F5#
      8'd131:  cur_note = '{p_f5, dur_eighth};   // F5
      8'd132:  cur_note = '{p_d5s, dur_quarter}; // D5#
      8'd133:  cur_note = '{p_e5, dur_quarter};  // E5
      8'd134:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd135:  cur_note = '{p_g4s, dur_eighth};  // G4#
      8'd136:  cur_note = '{p_a4, dur_eighth};   // A4
      8'd137:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd138:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd139:  cur_note = '{p_a4, dur_eighth};   // A4
      8'd140:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd141:  cur_note = '{p_d5, dur_eighth};   // D5
      8'd142:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd143:  cur_note = '{p_d5s, dur_quarter}; // D5#
      8'd144:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd145:  cur_note = '{p_d5, dur_quarter};  // D5
      8'd146:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd147:  cur_note = '{p_c5, dur_quarter};  // C5
      8'd148:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd149:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd150:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd151:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd152:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd153:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd154:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd155:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd156:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd157:  cur_note = '{p_d5, dur_quarter};  // D5
      8'd158:  cur_note = '{p_e5, dur_eighth};   // E5
      8'd159:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd160:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd161:  cur_note = '{p_a4, dur_eighth};   // A4
      8'd162:  cur_note = '{p_g4, dur_eighth};   // G4
      8'd163:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd164:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd165:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd166:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd167:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd168:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd169:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd170:  cur_note = '{p_d5, dur_eighth};   // D5
      8'd171:  cur_note = '{p_e5, dur_eighth};   // E5
      8'd172:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd173:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd174:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd175:  cur_note = '{p_rest, dur_quarter}; // rest
      8'd176:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd177:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd178:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd179:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd180:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd181:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd182:  cur_note = '{p_d5, dur_quarter};  // D5
      8'd183:  cur_note = '{p_e5, dur_eighth};   // E5
      8'd184:  cur_note = '{p_c5, dur_eighth};   // C5
      8'd185:  cur_note = '{p_rest, dur_eighth}; // rest
      8'd186:  cur_note = '{p_a4, dur_eighth};   // A4
      8'd187:  cur_note = '{p_g4, dur_eighth};   // G4
      8'd188:  cur_note = '{p_rest, dur_quarter}; // rest
      default: cur_note = '{p_rest, dur_eighth}; // unreachable position
    endcase
  end

  a_pos_in_song: assert property (@(posedge clk_100MHz) disable iff (reset)
    song_pos <= SONG_LAST);

endmodule

/* src/beat_timer.sv */
`timescale 1ns/1ps

module beat_timer import bgm_pkg::*; #(
  parameter int TICK_DIV = TICK_DIV_DEFAULT
) (
  input  logic  clk_100MHz,
  input  logic  reset,
  input  note_t cur_note,
  output logic  next_note,
  output logic  sound_on
);

  localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIV - 1);

  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  beat_cnt_t        beat_cnt;
  beat_cnt_t        last_tick;
  beat_cnt_t        sound_lim;

  // free-running tick divider
  always_ff @(posedge clk_100MHz) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign tick = (div_cnt == DIV_LAST);

  always_comb begin
    if (cur_note.dur == dur_quarter) begin
      last_tick = QUARTER_LAST_TICK;
      sound_lim = QUARTER_SOUND_TICKS;
    end else begin
      last_tick = EIGHTH_LAST_TICK;
      sound_lim = EIGHTH_SOUND_TICKS;
    end
  end

  assign next_note = tick && (beat_cnt == last_tick); // end of note

  always_ff @(posedge clk_100MHz) begin
    if (reset) begin
      beat_cnt <= '0;
    end else if (next_note) begin
      beat_cnt <= '0;
    end else if (tick) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  assign sound_on = (beat_cnt <= sound_lim); // gap before next note

  a_single_pulse: assert property (@(posedge clk_100MHz) disable iff (reset)
    next_note |=> !next_note);

  // duration only changes together with the counter wrap
  a_beat_in_range: assert property (@(posedge clk_100MHz) disable iff (reset)
    beat_cnt <= last_tick);

endmodule

/* src/tone_gen.sv */
`timescale 1ns/1ps

module tone_gen import bgm_pkg::*; #(
  parameter int PITCH_SHIFT = PITCH_SHIFT_DEFAULT
) (
  input  logic  clk_100MHz,
  input  logic  reset,
  input  logic  next_note,
  input  note_t cur_note,
  output logic  tone
);

  half_period_t half_lim;
  half_period_t cnt;

  // shift right by whole octaves
  assign half_lim = half_period_of(cur_note.pitch) >> PITCH_SHIFT;

  always_ff @(posedge clk_100MHz) begin
    if (reset) begin
      cnt  <= '0;
      tone <= 1'b0;
    end else if (next_note) begin
      cnt  <= '0; // new note starts in phase
      tone <= 1'b0;
    end else if (cnt == half_lim) begin
      cnt  <= '0;
      tone <= ~tone;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* src/bgm_player.sv */
`timescale 1ns/1ps

module bgm_player import bgm_pkg::*; #(
  parameter int TICK_DIV    = TICK_DIV_DEFAULT,
  parameter int PITCH_SHIFT = PITCH_SHIFT_DEFAULT
) (
  input  logic      clk_100MHz,
  input  logic      reset,
  output logic      audio,
  output song_pos_t song_pos
);

  note_t cur_note;
  logic  next_note;
  logic  sound_on;
  logic  tone;

  song_sequencer u_seq (
    .clk_100MHz (clk_100MHz),
    .reset      (reset),
    .next_note  (next_note),
    .song_pos   (song_pos),
    .cur_note   (cur_note)
  );

  beat_timer #(.TICK_DIV(TICK_DIV)) u_timer (
    .clk_100MHz (clk_100MHz),
    .reset      (reset),
    .cur_note   (cur_note),
    .next_note  (next_note),
    .sound_on   (sound_on)
  );

  tone_gen #(.PITCH_SHIFT(PITCH_SHIFT)) u_tone (
    .clk_100MHz (clk_100MHz),
    .reset      (reset),
    .next_note  (next_note),
    .cur_note   (cur_note),
    .tone       (tone)
  );

  assign audio = tone & sound_on & (cur_note.pitch != p_rest); // silent on rests and gaps

endmodule

/* dv/bgm_tb_tasks.svh */
task automatic compare_value(input string test, input int expected, input int actual);
  check_count++;
  assert (actual == expected) else begin
    $display("CHECK FAILED %s: expected %0d, actual %0d", test, expected, actual);
    error_count++;
  end
endtask

// note lengths of the song in groups of ten with e for eighth and q for quarter
function automatic bit is_quarter(input int pos);
  string seq;
  seq = {"eeeeeeqqqq", "qqeqeqeqqe", "qeeeqeeeqe", "eqeqeqeqeq",
         "qeqeeeqeee", "qeeqeqeeeq", "qeeeeeeeeq", "eeeqqeqeqq",
         "qeeeqqeeee", "eeeeqqeqeq", "qqqqeeeqqe", "eeeeeeeqee",
         "eqqeqeqqqe", "eeqqeeeeee", "eeqqeqeqqq", "qeeeeeeqee",
         "eeeqeeeeee", "eeqqqqeeee", "eeqeeeeeq"};
  return seq.getc(pos) == "q";
endfunction

function automatic int note_cycles(input int pos);
  return is_quarter(pos) ? QUARTER_CYCLES : EIGHTH_CYCLES;
endfunction

function automatic int silent_from(input int pos);
  return is_quarter(pos) ? QUARTER_SILENT : EIGHTH_SILENT;
endfunction

task automatic wait_for_pos(input song_pos_t pos);
  while (song_pos != pos) @(negedge clk_100MHz); // returns on the first cycle at pos
endtask

// plays out the current note, checks the silent tail and returns its length
task automatic measure_note(input string test, input int silent_start, output int length);
  song_pos_t start_pos;
  int        n;
  start_pos = song_pos;
  n = 0;
  while (song_pos == start_pos) begin
    @(negedge clk_100MHz);
    n++;
    if (song_pos == start_pos && n >= silent_start) begin
      compare_value($sformatf("%s audio at cycle %0d", test, n), 0, int'(audio));
    end
  end
  length = n;
endtask

// reset is already high for the next rising edge
task automatic hold_reset(input string test);
  int i;
  for (i = 0; i < RESET_CYCLES; i++) begin
    @(posedge clk_100MHz);
    if (i == RESET_CYCLES - 1) reset <= 1'b0;
    @(negedge clk_100MHz);
    compare_value({test, " song_pos in reset"}, 0, int'(song_pos));
    compare_value({test, " audio in reset"}, 0, int'(audio));
  end
  @(negedge clk_100MHz); // first cycle out of reset
  compare_value({test, " song_pos after reset"}, 0, int'(song_pos));
  compare_value({test, " audio after reset"}, 0, int'(audio));
endtask

task automatic check_reset();
  hold_reset("reset");
endtask

// position 1 repeats note 0 and starts on a clean note boundary
task automatic check_eighth_note();
  int   half_cycles;
  int   n;
  int   first_rise;
  int   first_fall;
  logic prev_audio;
  half_cycles = int'(half_period_of(p_e5) >> PITCH_SHIFT) + 1;
  first_rise = -1;
  first_fall = -1;
  wait_for_pos(8'd1);
  n = 0;
  prev_audio = audio;
  while (song_pos == 8'd1) begin
    @(negedge clk_100MHz);
    n++;
    if (audio && !prev_audio && first_rise < 0) first_rise = n;
    if (!audio && prev_audio && first_fall < 0) first_fall = n;
    if (song_pos == 8'd1 && n >= EIGHTH_SILENT) begin
      compare_value($sformatf("eighth_note audio at cycle %0d", n), 0, int'(audio));
    end
    prev_audio = audio;
  end
  compare_value("eighth_note length", EIGHTH_CYCLES, n);
  compare_value("eighth_note first edge", half_cycles, first_rise);
  compare_value("eighth_note edge spacing", half_cycles, first_fall - first_rise);
endtask

task automatic check_rest_note();
  int length;
  compare_value("rest_note position", 2, int'(song_pos));
  compare_value("rest_note audio at cycle 0", 0, int'(audio));
  measure_note("rest_note", 0, length); // a rest is silent throughout
  compare_value("rest_note length", EIGHTH_CYCLES, length);
endtask

task automatic check_quarter_note();
  int length;
  wait_for_pos(8'd6);
  measure_note("quarter_note", QUARTER_SILENT, length);
  compare_value("quarter_note length", QUARTER_CYCLES, length);
  compare_value("quarter_note next position", 7, int'(song_pos));
endtask

task automatic check_wrap();
  int pos;
  int length;
  for (pos = 7; pos <= int'(SONG_LAST); pos++) begin
    compare_value("wrap position", pos, int'(song_pos));
    measure_note($sformatf("wrap pos %0d", pos), silent_from(pos), length);
    compare_value($sformatf("wrap pos %0d length", pos), note_cycles(pos), length);
  end
  compare_value("wrap position after last note", 0, int'(song_pos));
endtask

task automatic check_mid_reset();
  wait_for_pos(8'd1);
  repeat (MID_RESET_DELAY) @(negedge clk_100MHz);
  @(posedge clk_100MHz);
  reset <= 1'b1;
  hold_reset("mid_reset");
endtask

/* dv/tb_bgm.sv */
`timescale 1ns/1ps

module tb_bgm import bgm_pkg::*; ();

  localparam int TICK_DIV        = 4;
  localparam int PITCH_SHIFT     = 8;
  localparam int RESET_CYCLES    = 16;
  localparam int MID_RESET_DELAY = 300; // lands inside the first tone pulse
  localparam int MARGIN_NOTES    = 20;

  // note lengths and start of the silent tail in clock cycles
  localparam int EIGHTH_CYCLES  = (int'(EIGHTH_LAST_TICK) + 1) * TICK_DIV;
  localparam int QUARTER_CYCLES = (int'(QUARTER_LAST_TICK) + 1) * TICK_DIV;
  localparam int EIGHTH_SILENT  = (int'(EIGHTH_SOUND_TICKS) + 1) * TICK_DIV;
  localparam int QUARTER_SILENT = (int'(QUARTER_SOUND_TICKS) + 1) * TICK_DIV;

  // one whole song of worst-case notes plus both resets and some slack
  localparam int TIMEOUT_CYCLES = 2 * RESET_CYCLES +
                                  (int'(SONG_LAST) + 1 + MARGIN_NOTES) * QUARTER_CYCLES;

  logic      clk_100MHz;
  logic      reset;
  logic      audio;
  song_pos_t song_pos;

  int error_count = 0;
  int check_count = 0;
  int cycle_cnt   = 0;

  bgm_player #(
    .TICK_DIV    (TICK_DIV),
    .PITCH_SHIFT (PITCH_SHIFT)
  ) uut (
    .clk_100MHz (clk_100MHz),
    .reset      (reset),
    .audio      (audio),
    .song_pos   (song_pos)
  );

  `include "bgm_tb_tasks.svh"

  initial begin
    clk_100MHz = 1'b0;
    forever #5 clk_100MHz = ~clk_100MHz; // 100 MHz
  end

  always @(posedge clk_100MHz) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the song did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", check_count, error_count);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    reset = 1'b1; // held from time zero

    check_reset();
    check_eighth_note();
    check_rest_note();
    check_quarter_note();
    check_wrap();
    check_mid_reset();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/bgm_pkg.sv
src/song_sequencer.sv
src/beat_timer.sv
src/tone_gen.sv
src/bgm_player.sv
+incdir+dv
dv/tb_bgm.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_bgm -f vlog.f -Mdir obj_dir
./obj_dir/Vtb_bgm > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
